// ==== source/rvvi_bridge_config.svh ====
// Width and size macros for the trace bridge, included by the packages and the RTL that sizes ports
`ifndef RVVI_BRIDGE_CONFIG_SVH
`define RVVI_BRIDGE_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Architecture widths
////////////////////////////////////////////////////////////////////////////

// Data and address width, RV32 only
`define RVVI_XLEN 32

// Machine CSRs tracked by the bridge
`define RVVI_NUM_CSR 10

////////////////////////////////////////////////////////////////////////////
// Trace bookkeeping
////////////////////////////////////////////////////////////////////////////

// Retirement order counter
`define RVVI_ORDER_W 64

`endif

// ==== source/rvfi_pkg.sv ====
// Types of the RVFI-style retirement record that the core hands to the trace bridge
`include "rvvi_bridge_config.svh"

package rvfi_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////////////////////////////////////////

    // SYSTEM / CSR format, csr field on top
    typedef struct packed {
        logic [11:0] csr;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rvfi_csr_form_t;

    // R-type register format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rvfi_reg_form_t;

    // Same 32 bits seen two ways
    typedef union packed {
        rvfi_csr_form_t csr_form;
        rvfi_reg_form_t reg_form;
    } rvfi_insn_u;

    ////////////////////////////////////////////////////////////////////////////
    // Retirement record
    ////////////////////////////////////////////////////////////////////////////

    // One record per retired instruction
    typedef struct packed {
        rvfi_insn_u              insn;
        logic [`RVVI_XLEN-1:0]   pc_rdata;
        logic [`RVVI_XLEN-1:0]   pc_wdata;
        logic [4:0]              rd_addr;
        logic [`RVVI_XLEN-1:0]   rd_wdata;
        logic                    csr_wen;
        logic [`RVVI_XLEN-1:0]   csr_wdata;
        logic                    trap;
        logic                    intr;
        logic                    halt;
        // Privilege mode of the retiring instruction
        logic [1:0]              mode;
    } rvfi_retire_t;

endpackage

// ==== source/rvvi_pkg.sv ====
// Types of the RVVI-style trace word and the supported machine CSR set
`include "rvvi_bridge_config.svh"

package rvvi_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Supported CSRs
    ////////////////////////////////////////////////////////////////////////////

    // Bit position inside the one-hot CSR flag word
    typedef enum logic [3:0] {
        CSR_ID_MISA      = 4'd0,
        CSR_ID_MVENDORID = 4'd1,
        CSR_ID_MARCHID   = 4'd2,
        CSR_ID_MIMPID    = 4'd3,
        CSR_ID_MHARTID   = 4'd4,
        CSR_ID_MSTATUS   = 4'd5,
        CSR_ID_MIE       = 4'd6,
        CSR_ID_MTVEC     = 4'd7,
        CSR_ID_MEPC      = 4'd8,
        CSR_ID_MCAUSE    = 4'd9
    } csr_id_e;

    // Architectural addresses
    typedef enum logic [11:0] {
        CSR_MISA      = 12'h301,
        CSR_MVENDORID = 12'hF11,
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14,
        CSR_MSTATUS   = 12'h300,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342
    } csr_addr_e;

    ////////////////////////////////////////////////////////////////////////////
    // Trace word
    ////////////////////////////////////////////////////////////////////////////

    // x1..x31 change flag, bit 0 never set
    typedef struct packed {
        logic [31:0]             x_wb;
        logic [`RVVI_XLEN-1:0]   x_wdata;
    } gpr_wb_t;

    typedef struct packed {
        logic [`RVVI_NUM_CSR-1:0] csr_wb;
        logic [`RVVI_XLEN-1:0]    csr_wdata;
    } csr_wb_t;

    typedef struct packed {
        logic [`RVVI_ORDER_W-1:0] order;
        logic [`RVVI_XLEN-1:0]    insn;
        logic [`RVVI_XLEN-1:0]    pc_rdata;
        logic [`RVVI_XLEN-1:0]    pc_wdata;
        gpr_wb_t                  gpr;
        csr_wb_t                  csr;
        logic                     trap;
        logic                     intr;
        logic                     halt;
        logic [1:0]               mode;
    } rvvi_trace_t;

endpackage

// ==== source/gpr_wb_decoder.sv ====
// Combinational decode of the register writeback into a one-hot change flag, used by the bridge top
`timescale 1ns/100ps

module gpr_wb_decoder import rvfi_pkg::*, rvvi_pkg::*; (
    // Retirement record from the core
    input  rvfi_retire_t retire_i,

    // Flag word and write value
    output gpr_wb_t      gpr_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Destination select
    ////////////////////////////////////////////////////////////////////////////

    // x0 is hardwired, never a change
    logic        rd_is_x0;
    logic [31:0] rd_onehot;

    assign rd_is_x0 = (retire_i.rd_addr == 5'd0);

    // Shifted single bit at rd
    always_comb begin
        rd_onehot = '0;
        rd_onehot[retire_i.rd_addr] = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Default no change
        gpr_o = '0;
        if (!rd_is_x0) begin
            gpr_o.x_wb    = rd_onehot;
            gpr_o.x_wdata = retire_i.rd_wdata;
        end
    end

endmodule

// ==== source/csr_wb_decoder.sv ====
// Combinational decode of the CSR field into a one-hot flag over the supported machine CSRs
`timescale 1ns/100ps
`include "rvvi_bridge_config.svh"

module csr_wb_decoder import rvfi_pkg::*, rvvi_pkg::*; (
    // Retirement record from the core
    input  rvfi_retire_t retire_i,

    // CSR flag word and write value
    output csr_wb_t      csr_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Address match
    ////////////////////////////////////////////////////////////////////////////

    logic [11:0]              csr_addr;
    csr_id_e                  csr_id;
    logic                     csr_hit;
    logic [`RVVI_NUM_CSR-1:0] csr_onehot;

    // csr field sits in insn[31:20]
    assign csr_addr = retire_i.insn.csr_form.csr;

    // Map address to flag position
    always_comb begin
        csr_id  = CSR_ID_MISA;
        csr_hit = 1'b1;
        case (csr_addr)
            // Machine information
            CSR_MISA:      csr_id = CSR_ID_MISA;
            CSR_MVENDORID: csr_id = CSR_ID_MVENDORID;
            CSR_MARCHID:   csr_id = CSR_ID_MARCHID;
            CSR_MIMPID:    csr_id = CSR_ID_MIMPID;
            CSR_MHARTID:   csr_id = CSR_ID_MHARTID;
            // Trap setup
            CSR_MSTATUS:   csr_id = CSR_ID_MSTATUS;
            CSR_MIE:       csr_id = CSR_ID_MIE;
            CSR_MTVEC:     csr_id = CSR_ID_MTVEC;
            // Trap handling
            CSR_MEPC:      csr_id = CSR_ID_MEPC;
            CSR_MCAUSE:    csr_id = CSR_ID_MCAUSE;
            // Not tracked
            default:       csr_hit = 1'b0;
        endcase
    end

    // Single bit at the matched position
    always_comb begin
        csr_onehot = '0;
        csr_onehot[csr_id] = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // No write or unknown CSR gives nothing
        csr_o = '0;
        if (retire_i.csr_wen && csr_hit) begin
            csr_o.csr_wb    = csr_onehot;
            csr_o.csr_wdata = retire_i.csr_wdata;
        end
    end

endmodule

// ==== source/trace_packer.sv ====
// Merges decoder results into the trace word and registers it behind a valid/ready stage
`timescale 1ns/100ps
`include "rvvi_bridge_config.svh"

module trace_packer import rvfi_pkg::*, rvvi_pkg::*; (
    input  logic         clk_i,
    input  logic         arst_n_i,

    // Retirement side
    input  rvfi_retire_t retire_i,
    input  logic         retire_valid_i,
    output logic         retire_ready_o,

    // Decoder results
    input  gpr_wb_t      gpr_i,
    input  csr_wb_t      csr_i,

    // Trace side
    output rvvi_trace_t  trace_o,
    output logic         trace_valid_o,
    input  logic         trace_ready_i
);

    logic                     accept;
    logic                     trace_valid_q;
    logic [`RVVI_ORDER_W-1:0] order_q;
    rvvi_trace_t              trace_d;
    rvvi_trace_t              trace_q;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////////////////////

    // Free slot, or the slot drains this cycle
    assign retire_ready_o = !trace_valid_q || trace_ready_i;
    assign accept         = retire_valid_i && retire_ready_o;

    ////////////////////////////////////////////////////////////////////////////
    // Word assembly
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        trace_d.order    = order_q;
        trace_d.insn     = retire_i.insn;
        trace_d.pc_rdata = retire_i.pc_rdata;
        trace_d.pc_wdata = retire_i.pc_wdata;
        trace_d.gpr      = gpr_i;
        trace_d.csr      = csr_i;
        trace_d.trap     = retire_i.trap;
        trace_d.intr     = retire_i.intr;
        trace_d.halt     = retire_i.halt;
        trace_d.mode     = retire_i.mode;
        // Trapped instruction writes nothing back
        if (retire_i.trap) begin
            trace_d.gpr = '0;
            trace_d.csr = '0;
        end
    end

    // Valid flag and order counter
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            trace_valid_q <= 1'b0;
            order_q       <= '0;
        end else if (accept) begin
            trace_valid_q <= 1'b1;
            order_q       <= order_q + 1'b1;
        end else if (trace_ready_i) begin
            trace_valid_q <= 1'b0;
        end
    end

    // Payload held until the next accept
    always_ff @(posedge clk_i) begin
        if (accept) begin
            trace_q <= trace_d;
        end
    end

    assign trace_o       = trace_q;
    assign trace_valid_o = trace_valid_q;

endmodule

// ==== source/rvvi_bridge.sv ====
// Top of the retirement-trace bridge, instantiate between the core's RVFI port and the tracer
`timescale 1ns/100ps

module rvvi_bridge import rvfi_pkg::*, rvvi_pkg::*; (
    input  logic         clk_i,
    input  logic         arst_n_i,

    // RVFI retirement input
    input  rvfi_retire_t retire_i,
    input  logic         retire_valid_i,
    output logic         retire_ready_o,

    // RVVI trace output
    output rvvi_trace_t  trace_o,
    output logic         trace_valid_o,
    input  logic         trace_ready_i
);

    // Decoder results, same cycle as retire_i
    gpr_wb_t gpr_wb;
    csr_wb_t csr_wb;

    gpr_wb_decoder gpr_wb_decoder_inst (
        .retire_i ( retire_i ),
        .gpr_o    ( gpr_wb )
    );

    csr_wb_decoder csr_wb_decoder_inst (
        .retire_i ( retire_i ),
        .csr_o    ( csr_wb )
    );

    // One register stage to the tracer
    trace_packer trace_packer_inst (
        .clk_i          ( clk_i ),
        .arst_n_i       ( arst_n_i ),
        .retire_i       ( retire_i ),
        .retire_valid_i ( retire_valid_i ),
        .retire_ready_o ( retire_ready_o ),
        .gpr_i          ( gpr_wb ),
        .csr_i          ( csr_wb ),
        .trace_o        ( trace_o ),
        .trace_valid_o  ( trace_valid_o ),
        .trace_ready_i  ( trace_ready_i )
    );

endmodule

// ==== test/tb_rvvi_bridge.sv ====
// Random-stimulus testbench for the trace bridge, run from build.sh against a reference model
`timescale 1ns/100ps

module tb_rvvi_bridge import rvfi_pkg::*, rvvi_pkg::*; ();

    localparam int NUM_RECORDS = 2000;

    logic         clk_i;
    logic         arst_n_i;
    rvfi_retire_t retire_i;
    logic         retire_valid_i;
    logic         retire_ready_o;
    rvvi_trace_t  trace_o;
    logic         trace_valid_o;
    logic         trace_ready_i;

    // LCG state, retirement counter of the model, expected words in flight
    logic [31:0]  rng_state;
    logic [63:0]  order_cnt;
    rvvi_trace_t  exp_q[$];

    rvvi_bridge i_dut (
        .clk_i          ( clk_i ),
        .arst_n_i       ( arst_n_i ),
        .retire_i       ( retire_i ),
        .retire_valid_i ( retire_valid_i ),
        .retire_ready_o ( retire_ready_o ),
        .trace_o        ( trace_o ),
        .trace_valid_o  ( trace_valid_o ),
        .trace_ready_i  ( trace_ready_i )
    );

    // 4 ns clock
    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp)
            report_mismatch($sformatf("%s got %b exp %b", what, got, exp));
    endtask

    task automatic check_gpr(gpr_wb_t got, gpr_wb_t exp);
        if (got !== exp)
            report_mismatch($sformatf("gpr x_wb %h x_wdata %h, exp %h %h",
                got.x_wb, got.x_wdata, exp.x_wb, exp.x_wdata));
    endtask

    task automatic check_csr(csr_wb_t got, csr_wb_t exp);
        if (got !== exp)
            report_mismatch($sformatf("csr csr_wb %b csr_wdata %h, exp %b %h",
                got.csr_wb, got.csr_wdata, exp.csr_wb, exp.csr_wdata));
    endtask

    // Order, pass-through fields and status bits
    task automatic check_trace(rvvi_trace_t got, rvvi_trace_t exp);
        if (got.order !== exp.order)
            report_mismatch($sformatf("order %0d exp %0d", got.order, exp.order));
        if (got.insn !== exp.insn || got.pc_rdata !== exp.pc_rdata
                || got.pc_wdata !== exp.pc_wdata)
            report_mismatch($sformatf("insn/pc %h %h %h exp %h %h %h", got.insn,
                got.pc_rdata, got.pc_wdata, exp.insn, exp.pc_rdata, exp.pc_wdata));
        if ({got.trap, got.intr, got.halt, got.mode} !== {exp.trap, exp.intr, exp.halt, exp.mode})
            report_mismatch($sformatf("trap/intr/halt/mode %b exp %b",
                {got.trap, got.intr, got.halt, got.mode},
                {exp.trap, exp.intr, exp.halt, exp.mode}));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Machine CSR address by flag position
    function automatic logic [11:0] csr_addr_at(int idx);
        case (idx)
            0: return 12'h301;
            1: return 12'hF11;
            2: return 12'hF12;
            3: return 12'hF13;
            4: return 12'hF14;
            5: return 12'h300;
            6: return 12'h304;
            7: return 12'h305;
            8: return 12'h341;
            default: return 12'h342;
        endcase
    endfunction

    // Flag position, -1 when not tracked
    function automatic int csr_index(logic [11:0] addr);
        for (int i = 0; i < 10; i++)
            if (csr_addr_at(i) == addr)
                return i;
        return -1;
    endfunction

    function automatic rvvi_trace_t model_trace(rvfi_retire_t r, logic [63:0] order);
        rvvi_trace_t t;
        int          idx;
        t          = '0;
        t.order    = order;
        t.insn     = r.insn;
        t.pc_rdata = r.pc_rdata;
        t.pc_wdata = r.pc_wdata;
        t.trap     = r.trap;
        t.intr     = r.intr;
        t.halt     = r.halt;
        t.mode     = r.mode;
        idx = csr_index({r.insn.reg_form.funct7, r.insn.reg_form.rs2});
        // Trapped instruction reports no writeback
        if (!r.trap) begin
            if (r.rd_addr != 5'd0) begin
                t.gpr.x_wb    = 32'd1 << r.rd_addr;
                t.gpr.x_wdata = r.rd_wdata;
            end
            if (r.csr_wen && idx >= 0) begin
                t.csr.csr_wb    = 10'd1 << idx;
                t.csr.csr_wdata = r.csr_wdata;
            end
        end
        return t;
    endfunction

    // Upper LCG bits only, the low ones cycle too fast
    function automatic rvfi_retire_t random_record();
        rvfi_retire_t r;
        logic [31:0]  rnd;
        logic [11:0]  addr;
        r.insn      = lcg_next();
        r.pc_rdata  = lcg_next() & 32'hFFFF_FFFC;
        r.pc_wdata  = lcg_next() & 32'hFFFF_FFFC;
        r.rd_wdata  = lcg_next();
        r.csr_wdata = lcg_next();
        rnd         = lcg_next();
        r.rd_addr   = rnd[31:27];
        r.csr_wen   = rnd[26];
        r.trap      = (rnd[25:23] == 3'd0);
        r.intr      = rnd[22];
        r.halt      = (rnd[21:18] == 4'd0);
        r.mode      = rnd[17:16];
        // Mostly tracked CSRs, one in eight anything
        rnd = lcg_next();
        if (rnd[31:29] == 3'd0)
            addr = rnd[27:16];
        else
            addr = csr_addr_at(int'(rnd[28:16]) % 10);
        r.insn.reg_form.funct7 = addr[11:5];
        r.insn.reg_form.rs2    = addr[4:0];
        return r;
    endfunction

    // Register stage holds at most the one word the queue predicts
    task automatic check_output();
        if (exp_q.size() == 0) begin
            check_flag(trace_valid_o, 1'b0, "trace_valid_o with nothing pending");
        end else begin
            check_flag(trace_valid_o, 1'b1, "trace_valid_o after accept");
            check_gpr(trace_o.gpr, exp_q[0].gpr);
            check_csr(trace_o.csr, exp_q[0].csr);
            check_trace(trace_o, exp_q[0]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rnd;
        logic        taken;
        int          n_in;
        int          n_out;
        rng_state      = 32'h120ccef0;
        order_cnt      = '0;
        n_in           = 0;
        n_out          = 0;
        taken          = 1'b0;
        arst_n_i       = 1'b0;
        retire_i       = '0;
        retire_valid_i = 1'b0;
        trace_ready_i  = 1'b0;
        repeat (5) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        while (n_out < NUM_RECORDS) begin
            @(posedge clk_i);
            #1;
            if (taken)
                retire_valid_i = 1'b0;
            rnd = lcg_next();
            // Untaken record stays on the bus
            if (!retire_valid_i && n_in < NUM_RECORDS && rnd[31:30] != 2'd0) begin
                retire_i       = random_record();
                retire_valid_i = 1'b1;
            end
            trace_ready_i = (rnd[29:28] != 2'd0);
            // Mid-cycle, all inputs and outputs settled
            @(negedge clk_i);
            check_output();
            // Model register empty, or it drains this cycle
            check_flag(retire_ready_o, exp_q.size() == 0 || trace_ready_i, "retire_ready_o");
            if (trace_valid_o && trace_ready_i) begin
                void'(exp_q.pop_front());
                n_out++;
            end
            taken = retire_valid_i && retire_ready_o;
            if (taken) begin
                exp_q.push_back(model_trace(retire_i, order_cnt));
                order_cnt = order_cnt + 64'd1;
                n_in++;
            end
        end
        // One idle cycle, no word may remain or appear
        @(posedge clk_i);
        #1;
        retire_valid_i = 1'b0;
        trace_ready_i  = 1'b0;
        @(negedge clk_i);
        if (exp_q.size() != 0 || trace_valid_o !== 1'b0) begin
            $display("Trace output still busy after the last record was delivered");
            stop_run();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

    // Watchdog, generous for the stall rate
    initial begin
        #(NUM_RECORDS * 40);
        $display("Timeout: the trace output did not deliver all records in time");
        stop_run();
    end

endmodule

// ==== rvvi_bridge.f ====
+incdir+source
source/rvfi_pkg.sv
source/rvvi_pkg.sv
source/gpr_wb_decoder.sv
source/csr_wb_decoder.sv
source/trace_packer.sv
source/rvvi_bridge.sv
test/tb_rvvi_bridge.sv

// ==== build.sh ====
#!/bin/sh
# Compile the trace bridge testbench with Verilator and run it.
# The exit status of the simulation is the verdict.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_rvvi_bridge \
    -f rvvi_bridge.f \
    -o tb_rvvi_bridge

./obj_dir/tb_rvvi_bridge
